// File: design/gpio_ahb_slave.sv
`timescale 1ns/10ps
`default_nettype none

`include "gpio_macros.svh"

module gpio_ahb_slave
    import gpio_pkg::*;
(
    input  logic                   HCLK,
    input  logic                   HRESETn,
    input  logic                   i_hsel,
    input  logic [31:0]            i_haddr,
    input  logic [1:0]             i_htrans,
    input  logic [2:0]             i_hsize,
    input  logic                   i_hwrite,
    input  logic [31:0]            i_hwdata,
    input  logic                   i_hready,
    input  logic [`GPIO_PIN_W-1:0] i_oe,
    input  logic [`GPIO_PIN_W-1:0] i_dat,
    input  logic [`GPIO_PIN_W-1:0] i_pin_in,
    output logic                   o_hreadyout,
    output logic [31:0]            o_hrdata,
    output logic                   o_hresp,
    output logic                   o_wr_oe,
    output logic                   o_wr_dat,
    output logic [1:0]             o_wr_port,
    output logic [3:0]             o_wr_lanes,
    output gpio_word_u             o_wr_data
);

    logic                   accept;
    logic                   grp_ok;
    logic [3:0]             reg_ofs;
    logic [3:0]             lane_dec;
    logic                   wr_oe_q;
    logic                   wr_dat_q;
    logic                   rd_q;
    logic [1:0]             port_q;
    logic [3:0]             ofs_q;
    logic [3:0]             lanes_q;
    logic [`GPIO_PORT_W-1:0] in_word;
    logic [`GPIO_PORT_W-1:0] oe_word;
    logic [`GPIO_PORT_W-1:0] dat_word;

    // Zero wait states, always OKAY
    assign o_hreadyout = 1'b1;
    assign o_hresp     = 1'b0;

    assign accept  = i_hsel & i_htrans[1] & i_hready;
    assign grp_ok  = (i_haddr[7:4] < `GPIO_NUM_PORTS);
    assign reg_ofs = {i_haddr[3:2], 2'b00};

    // Byte lanes from size and low address bits
    always_comb
    begin
        case ({i_hsize, i_haddr[1:0]})
            5'b000_00: lane_dec = 4'b0001;
            5'b000_01: lane_dec = 4'b0010;
            5'b000_10: lane_dec = 4'b0100;
            5'b000_11: lane_dec = 4'b1000;
            5'b001_00: lane_dec = 4'b0011;
            5'b001_10: lane_dec = 4'b1100;
            5'b010_00: lane_dec = 4'b1111;
            default:   lane_dec = 4'b0000;
        endcase
    end

    // Address phase capture
    always_ff @(posedge HCLK or negedge HRESETn)
    begin
        if (!HRESETn)
        begin
            wr_oe_q  <= 1'b0;
            wr_dat_q <= 1'b0;
            rd_q     <= 1'b0;
            port_q   <= 2'b00;
            ofs_q    <= 4'h0;
            lanes_q  <= 4'h0;
        end
        else
        begin
            wr_oe_q  <= accept & i_hwrite & grp_ok & (reg_ofs == `GPIO_OFS_OE);
            wr_dat_q <= accept & i_hwrite & grp_ok & (reg_ofs == `GPIO_OFS_DAT);
            rd_q     <= accept & ~i_hwrite & grp_ok;
            if (accept)
            begin
                port_q  <= i_haddr[5:4];
                ofs_q   <= reg_ofs;
                lanes_q <= lane_dec;
            end
        end
    end

    // Data phase write request
    assign o_wr_oe    = wr_oe_q;
    assign o_wr_dat   = wr_dat_q;
    assign o_wr_port  = port_q;
    assign o_wr_lanes = lanes_q;

    always_comb
    begin
        o_wr_data.word = i_hwdata;
    end

    assign in_word  = i_pin_in[port_q*`GPIO_PORT_W +: `GPIO_PORT_W];
    assign oe_word  = i_oe[port_q*`GPIO_PORT_W +: `GPIO_PORT_W];
    assign dat_word = i_dat[port_q*`GPIO_PORT_W +: `GPIO_PORT_W];

    // Readback, zero outside a read data phase
    always_comb
    begin
        o_hrdata = '0;
        if (rd_q)
        begin
            case (ofs_q)
                `GPIO_OFS_IN:  o_hrdata = in_word;
                `GPIO_OFS_OE:  o_hrdata = oe_word;
                `GPIO_OFS_DAT: o_hrdata = dat_word;
                default:       o_hrdata = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: design/gpio_macros.svh
`ifndef GPIO_MACROS_SVH
`define GPIO_MACROS_SVH

// Port geometry
`define GPIO_NUM_PORTS 4
`define GPIO_PORT_W    32

// Total pin count across all ports
`define GPIO_PIN_W     (`GPIO_NUM_PORTS * `GPIO_PORT_W)

// Register offsets within one port, word aligned
`define GPIO_OFS_IN    4'h0
`define GPIO_OFS_OE    4'h4
`define GPIO_OFS_DAT   4'h8

`endif

// File: design/gpio_pins.sv
`timescale 1ns/10ps
`default_nettype none

`include "gpio_macros.svh"

module gpio_pins
(
    input  logic                   HCLK,
    input  logic                   HRESETn,
    input  logic [`GPIO_PIN_W-1:0] i_oe,
    input  logic [`GPIO_PIN_W-1:0] i_dat,
    output logic [`GPIO_PIN_W-1:0] o_pin_in,
    inout  wire  [`GPIO_PIN_W-1:0] io_pin
);

    logic [`GPIO_PIN_W-1:0] sync1_q;
    logic [`GPIO_PIN_W-1:0] sync2_q;

    // Tri-state driver per pin
    for (genvar i = 0; i < `GPIO_PIN_W; i++)
    begin : g_pin
        assign io_pin[i] = i_oe[i] ? i_dat[i] : 1'bz;
    end

    // Two-flop synchronizer on the pin levels
    always_ff @(posedge HCLK or negedge HRESETn)
    begin
        if (!HRESETn)
        begin
            sync1_q <= '0;
            sync2_q <= '0;
        end
        else
        begin
            sync1_q <= io_pin;
            sync2_q <= sync1_q;
        end
    end

    assign o_pin_in = sync2_q;

endmodule

`default_nettype wire

// File: design/gpio_pkg.sv
`default_nettype none

`include "gpio_macros.svh"

package gpio_pkg;

    // Register word, whole or per byte lane
    typedef union packed
    {
        logic [`GPIO_PORT_W-1:0]        word;
        logic [`GPIO_PORT_W/8-1:0][7:0] bytes;
    } gpio_word_u;

endpackage

`default_nettype wire

// File: design/gpio_regs.sv
`timescale 1ns/10ps
`default_nettype none

`include "gpio_macros.svh"

module gpio_regs
    import gpio_pkg::*;
(
    input  logic                   HCLK,
    input  logic                   HRESETn,
    input  logic                   i_wr_oe,
    input  logic                   i_wr_dat,
    input  logic [1:0]             i_wr_port,
    input  logic [3:0]             i_wr_lanes,
    input  gpio_word_u             i_wr_data,
    output logic [`GPIO_PIN_W-1:0] o_oe,
    output logic [`GPIO_PIN_W-1:0] o_dat
);

    gpio_word_u oe_q  [`GPIO_NUM_PORTS];
    gpio_word_u dat_q [`GPIO_NUM_PORTS];

    always_ff @(posedge HCLK or negedge HRESETn)
    begin
        if (!HRESETn)
        begin
            for (int p = 0; p < `GPIO_NUM_PORTS; p++)
            begin
                oe_q[p]  <= '0;
                dat_q[p] <= '0;
            end
        end
        else
        begin
            // Only the enabled lanes of the addressed word
            for (int b = 0; b < `GPIO_PORT_W/8; b++)
            begin
                if (i_wr_oe && i_wr_lanes[b])
                begin
                    oe_q[i_wr_port].bytes[b] <= i_wr_data.bytes[b];
                end
                if (i_wr_dat && i_wr_lanes[b])
                begin
                    dat_q[i_wr_port].bytes[b] <= i_wr_data.bytes[b];
                end
            end
        end
    end

    // Flatten per-port words onto the pin buses
    always_comb
    begin
        for (int p = 0; p < `GPIO_NUM_PORTS; p++)
        begin
            o_oe[p*`GPIO_PORT_W +: `GPIO_PORT_W]  = oe_q[p].word;
            o_dat[p*`GPIO_PORT_W +: `GPIO_PORT_W] = dat_q[p].word;
        end
    end

endmodule

`default_nettype wire

// File: design/gpio_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "gpio_macros.svh"

module gpio_top
    import gpio_pkg::*;
(
    input  logic                   HCLK,
    input  logic                   HRESETn,
    input  logic                   i_hsel,
    input  logic [31:0]            i_haddr,
    input  logic [1:0]             i_htrans,
    input  logic [2:0]             i_hsize,
    input  logic                   i_hwrite,
    input  logic [31:0]            i_hwdata,
    input  logic                   i_hready,
    output logic                   o_hreadyout,
    output logic [31:0]            o_hrdata,
    output logic                   o_hresp,
    inout  wire  [`GPIO_PIN_W-1:0] io_pin
);

    logic                   wr_oe;
    logic                   wr_dat;
    logic [1:0]             wr_port;
    logic [3:0]             wr_lanes;
    gpio_word_u             wr_data;
    logic [`GPIO_PIN_W-1:0] oe;
    logic [`GPIO_PIN_W-1:0] dat;
    logic [`GPIO_PIN_W-1:0] pin_in;

    gpio_ahb_slave slave_i
    (
        .HCLK        (HCLK),
        .HRESETn     (HRESETn),
        .i_hsel      (i_hsel),
        .i_haddr     (i_haddr),
        .i_htrans    (i_htrans),
        .i_hsize     (i_hsize),
        .i_hwrite    (i_hwrite),
        .i_hwdata    (i_hwdata),
        .i_hready    (i_hready),
        .i_oe        (oe),
        .i_dat       (dat),
        .i_pin_in    (pin_in),
        .o_hreadyout (o_hreadyout),
        .o_hrdata    (o_hrdata),
        .o_hresp     (o_hresp),
        .o_wr_oe     (wr_oe),
        .o_wr_dat    (wr_dat),
        .o_wr_port   (wr_port),
        .o_wr_lanes  (wr_lanes),
        .o_wr_data   (wr_data)
    );

    gpio_regs regs_i
    (
        .HCLK       (HCLK),
        .HRESETn    (HRESETn),
        .i_wr_oe    (wr_oe),
        .i_wr_dat   (wr_dat),
        .i_wr_port  (wr_port),
        .i_wr_lanes (wr_lanes),
        .i_wr_data  (wr_data),
        .o_oe       (oe),
        .o_dat      (dat)
    );

    gpio_pins pins_i
    (
        .HCLK     (HCLK),
        .HRESETn  (HRESETn),
        .i_oe     (oe),
        .i_dat    (dat),
        .o_pin_in (pin_in),
        .io_pin   (io_pin)
    );

endmodule

`default_nettype wire

// File: flist.f
+incdir+design
design/gpio_pkg.sv
design/gpio_ahb_slave.sv
design/gpio_regs.sv
design/gpio_pins.sv
design/gpio_top.sv
verif/gpio_assert.sv
verif/gpio_tb.sv

// File: verif/gpio_assert.sv
`timescale 1ns/10ps
`default_nettype none

module gpio_assert
(
    input logic        HCLK,
    input logic        HRESETn,
    input logic        i_hsel,
    input logic [1:0]  i_htrans,
    input logic        i_hwrite,
    input logic        i_hready,
    input logic        i_hreadyout,
    input logic        i_hresp,
    input logic [31:0] i_hrdata
);

    int   fail_cnt = 0;
    logic rd_accept;

    assign rd_accept = i_hsel & i_htrans[1] & i_hready & ~i_hwrite;

    // Zero wait states and OKAY outside reset
    resp_okay: assert property (@(posedge HCLK) disable iff (!HRESETn)
        i_hreadyout && !i_hresp)
    else
    begin
        $error("HREADYOUT low or HRESP not OKAY");
        fail_cnt++;
    end

    // Read bus idles at zero outside a read data phase
    rdata_idle: assert property (@(posedge HCLK) disable iff (!HRESETn)
        !$past(rd_accept) |-> (i_hrdata == 32'h0))
    else
    begin
        $error("HRDATA nonzero outside a read data phase");
        fail_cnt++;
    end

endmodule

bind gpio_top gpio_assert assert_i
(
    .HCLK        (HCLK),
    .HRESETn     (HRESETn),
    .i_hsel      (i_hsel),
    .i_htrans    (i_htrans),
    .i_hwrite    (i_hwrite),
    .i_hready    (i_hready),
    .i_hreadyout (o_hreadyout),
    .i_hresp     (o_hresp),
    .i_hrdata    (o_hrdata)
);

`default_nettype wire

// File: verif/gpio_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "gpio_macros.svh"

module gpio_tb;

    // Roughly 750 cycles of tests, with ample margin
    localparam int TIMEOUT_CYCLES = 4000;

    logic                   HCLK;
    logic                   HRESETn;
    logic                   i_hsel;
    logic [31:0]            i_haddr;
    logic [1:0]             i_htrans;
    logic [2:0]             i_hsize;
    logic                   i_hwrite;
    logic [31:0]            i_hwdata;
    logic                   i_hready;
    wire                    o_hreadyout;
    wire  [31:0]            o_hrdata;
    wire                    o_hresp;
    wire  [`GPIO_PIN_W-1:0] io_pin;

    logic [31:0]            sh_oe  [`GPIO_NUM_PORTS];
    logic [31:0]            sh_dat [`GPIO_NUM_PORTS];
    logic [`GPIO_PIN_W-1:0] lag_oe;
    logic [`GPIO_PIN_W-1:0] pin_lvl;
    logic [`GPIO_PIN_W-1:0] exp_pins;
    logic                   float_pins;
    logic                   rd_ph;
    logic [31:0]            rd_addr;
    logic [31:0]            exp_rd;
    int                     seed;
    int                     cycles;

    always #50 HCLK = ~HCLK;

    gpio_top dut_i
    (
        .HCLK        (HCLK),
        .HRESETn     (HRESETn),
        .i_hsel      (i_hsel),
        .i_haddr     (i_haddr),
        .i_htrans    (i_htrans),
        .i_hsize     (i_hsize),
        .i_hwrite    (i_hwrite),
        .i_hwdata    (i_hwdata),
        .i_hready    (i_hready),
        .o_hreadyout (o_hreadyout),
        .o_hrdata    (o_hrdata),
        .o_hresp     (o_hresp),
        .io_pin      (io_pin)
    );

    // External drivers back off where the DUT drives
    for (genvar i = 0; i < `GPIO_PIN_W; i++)
    begin : g_pin_model
        assign io_pin[i] = (lag_oe[i] || float_pins) ? 1'bz : pin_lvl[i];
        pullup pu (io_pin[i]);
    end

    // Shadow enables as the DUT holds them, one edge later
    always @(posedge HCLK)
    begin
        for (int p = 0; p < `GPIO_NUM_PORTS; p++)
        begin
            lag_oe[p*`GPIO_PORT_W +: `GPIO_PORT_W] <= sh_oe[p];
        end
    end

    function automatic logic [31:0] reg_addr(input int grp, input logic [3:0] ofs);
        return {24'h0, grp[3:0], ofs};
    endfunction

    function automatic logic [3:0] lane_mask(input logic [2:0] size, input logic [1:0] ofs);
        if (size == 3'd0)
            return 4'b0001 << ofs;
        if (size == 3'd1 && !ofs[0])
            return ofs[1] ? 4'b1100 : 4'b0011;
        if (size == 3'd2 && ofs == 2'b00)
            return 4'b1111;
        return 4'b0000;
    endfunction

    function automatic logic [31:0] merge_lanes(input logic [31:0] old,
                                                input logic [31:0] data,
                                                input logic [3:0]  lanes);
        logic [31:0] res;
        res = old;
        for (int b = 0; b < 4; b++)
        begin
            if (lanes[b])
                res[b*8 +: 8] = data[b*8 +: 8];
        end
        return res;
    endfunction

    // Expected read word from the register map and the shadow state
    function automatic logic [31:0] ref_read(input logic [31:0] addr);
        int          g;
        logic [31:0] lvl;
        g = addr[7:4];
        if (g >= `GPIO_NUM_PORTS)
            return '0;
        lvl = pin_lvl[g*`GPIO_PORT_W +: `GPIO_PORT_W];
        case ({addr[3:2], 2'b00})
            `GPIO_OFS_IN:  return (sh_oe[g] & sh_dat[g]) | (~sh_oe[g] & lvl);
            `GPIO_OFS_OE:  return sh_oe[g];
            `GPIO_OFS_DAT: return sh_dat[g];
            default:       return '0;
        endcase
    endfunction

    task automatic report_mismatch(input string name, input logic [127:0] exp,
                                   input logic [127:0] act);
        $display("ERROR at %0t: %s expected %0h, got %0h", $time, name, exp, act);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic shadow_write(input logic [31:0] addr, input logic [2:0] size,
                                input logic [31:0] data);
        int         g;
        logic [3:0] lanes;
        g = addr[7:4];
        lanes = lane_mask(size, addr[1:0]);
        if ({addr[3:2], 2'b00} == `GPIO_OFS_OE)
            sh_oe[g] <= merge_lanes(sh_oe[g], data, lanes);
        else if ({addr[3:2], 2'b00} == `GPIO_OFS_DAT)
            sh_dat[g] <= merge_lanes(sh_dat[g], data, lanes);
    endtask

    // One transfer, address phase then data phase
    task automatic xfer(input logic wr, input logic [31:0] addr, input logic [2:0] size,
                        input logic [31:0] data, input logic sel, input logic [1:0] trans,
                        input logic rdy);
        @(posedge HCLK);
        i_hsel   <= sel;
        i_haddr  <= addr;
        i_htrans <= trans;
        i_hsize  <= size;
        i_hwrite <= wr;
        i_hready <= rdy;
        @(posedge HCLK);
        i_hsel   <= 1'b0;
        i_htrans <= 2'b00;
        i_hwrite <= 1'b0;
        i_hready <= 1'b1;
        i_hwdata <= wr ? data : 32'h0;
        if (wr && sel && trans[1] && rdy && addr[7:4] < `GPIO_NUM_PORTS)
            shadow_write(addr, size, data);
    endtask

    task automatic write_reg(input logic [31:0] addr, input logic [2:0] size,
                             input logic [31:0] data);
        xfer(1'b1, addr, size, data, 1'b1, 2'b10, 1'b1);
    endtask

    task automatic read_reg(input logic [31:0] addr);
        xfer(1'b0, addr, 3'd2, 32'h0, 1'b1, 2'b10, 1'b1);
    endtask

    // Read address phase overlaps the write data phase
    task automatic write_read(input logic [31:0] addr, input logic [31:0] data);
        @(posedge HCLK);
        i_hsel   <= 1'b1;
        i_haddr  <= addr;
        i_htrans <= 2'b10;
        i_hsize  <= 3'd2;
        i_hwrite <= 1'b1;
        @(posedge HCLK);
        i_hwrite <= 1'b0;
        i_hwdata <= data;
        shadow_write(addr, 3'd2, data);
        @(posedge HCLK);
        i_hsel   <= 1'b0;
        i_htrans <= 2'b00;
    endtask

    // Track read data phases from the bus itself
    always @(posedge HCLK)
    begin
        rd_ph   <= HRESETn && i_hsel && i_htrans[1] && i_hready && !i_hwrite;
        rd_addr <= i_haddr;
    end

    always @(negedge HCLK)
    begin
        if (HRESETn)
        begin
            exp_rd = rd_ph ? ref_read(rd_addr) : 32'h0;
            assert (o_hrdata === exp_rd)
            else
                report_mismatch("o_hrdata", exp_rd, o_hrdata);
        end
        assert (dut_i.assert_i.fail_cnt == 0)
        else
        begin
            $display("A bound bus protocol assertion failed at %0t", $time);
            $display("Simulation failed");
            $fatal(1);
        end
    end

    always @(posedge HCLK)
    begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES)
        begin
            $display("Run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
            $display("Simulation failed");
            $fatal(1);
        end
    end

    initial
    begin
        logic [31:0] addr;
        seed = 32'h5af9c502;
        HCLK = 1'b0;
        HRESETn = 1'b0;
        i_hsel = 1'b0;
        i_haddr = 32'h0;
        i_htrans = 2'b00;
        i_hsize = 3'd0;
        i_hwrite = 1'b0;
        i_hwdata = 32'h0;
        i_hready = 1'b1;
        float_pins = 1'b1;
        pin_lvl = '0;
        lag_oe = '0;
        rd_ph = 1'b0;
        rd_addr = 32'h0;
        cycles = 0;
        for (int p = 0; p < `GPIO_NUM_PORTS; p++)
        begin
            sh_oe[p] = 32'h0;
            sh_dat[p] = 32'h0;
        end
        repeat (10) @(posedge HCLK);
        HRESETn <= 1'b1;

        // Reset state, pins left to the pull-ups
        for (int p = 0; p < `GPIO_NUM_PORTS; p++)
        begin
            read_reg(reg_addr(p, `GPIO_OFS_OE));
            read_reg(reg_addr(p, `GPIO_OFS_DAT));
        end
        @(negedge HCLK);
        assert (io_pin === {`GPIO_PIN_W{1'b1}})
        else
            report_mismatch("io_pin", {`GPIO_PIN_W{1'b1}}, io_pin);
        @(posedge HCLK);
        float_pins <= 1'b0;
        pin_lvl <= {$random(seed), $random(seed), $random(seed), $random(seed)};

        // Word writes
        for (int p = 0; p < `GPIO_NUM_PORTS; p++)
        begin
            write_reg(reg_addr(p, `GPIO_OFS_OE), 3'd2, $random(seed));
            write_reg(reg_addr(p, `GPIO_OFS_DAT), 3'd2, $random(seed));
            read_reg(reg_addr(p, `GPIO_OFS_OE));
            read_reg(reg_addr(p, `GPIO_OFS_DAT));
        end

        // Every size at every low address, legal or not
        for (int p = 0; p < `GPIO_NUM_PORTS; p++)
        begin
            for (int r = 0; r < 2; r++)
            begin
                for (int a = 0; a < 4; a++)
                begin
                    for (int s = 0; s < 4; s++)
                    begin
                        addr = reg_addr(p, r ? `GPIO_OFS_DAT : `GPIO_OFS_OE) | a;
                        write_reg(addr, s[2:0], $random(seed));
                        read_reg(addr & ~32'h3);
                    end
                end
            end
        end

        // Pins, outputs and synchronized inputs
        for (int n = 0; n < 2; n++)
        begin
            for (int p = 0; p < `GPIO_NUM_PORTS; p++)
            begin
                write_reg(reg_addr(p, `GPIO_OFS_OE), 3'd2, $random(seed));
                write_reg(reg_addr(p, `GPIO_OFS_DAT), 3'd2, $random(seed));
            end
            @(posedge HCLK);
            pin_lvl <= {$random(seed), $random(seed), $random(seed), $random(seed)};
            repeat (4) @(posedge HCLK);
            @(negedge HCLK);
            for (int p = 0; p < `GPIO_NUM_PORTS; p++)
            begin
                exp_pins[p*`GPIO_PORT_W +: `GPIO_PORT_W] = (sh_oe[p] & sh_dat[p]) |
                    (~sh_oe[p] & pin_lvl[p*`GPIO_PORT_W +: `GPIO_PORT_W]);
            end
            assert (io_pin === exp_pins)
            else
                report_mismatch("io_pin", exp_pins, io_pin);
            for (int p = 0; p < `GPIO_NUM_PORTS; p++)
            begin
                read_reg(reg_addr(p, `GPIO_OFS_IN));
            end
        end

        // Accesses that must be ignored
        read_reg(reg_addr(0, 4'hC));
        write_reg(reg_addr(0, 4'hC), 3'd2, $random(seed));
        write_reg(reg_addr(1, `GPIO_OFS_IN), 3'd2, $random(seed));
        for (int g = `GPIO_NUM_PORTS; g < 16; g++)
        begin
            read_reg(reg_addr(g, `GPIO_OFS_OE));
            write_reg(reg_addr(g, `GPIO_OFS_DAT), 3'd2, $random(seed));
        end
        xfer(1'b1, reg_addr(2, `GPIO_OFS_OE), 3'd2, $random(seed), 1'b0, 2'b10, 1'b1);
        xfer(1'b1, reg_addr(2, `GPIO_OFS_DAT), 3'd2, $random(seed), 1'b1, 2'b00, 1'b1);
        xfer(1'b1, reg_addr(3, `GPIO_OFS_DAT), 3'd2, $random(seed), 1'b1, 2'b10, 1'b0);
        xfer(1'b0, reg_addr(3, `GPIO_OFS_DAT), 3'd2, 32'h0, 1'b0, 2'b10, 1'b1);
        xfer(1'b0, reg_addr(3, `GPIO_OFS_OE), 3'd2, 32'h0, 1'b1, 2'b10, 1'b0);
        for (int p = 0; p < `GPIO_NUM_PORTS; p++)
        begin
            read_reg(reg_addr(p, `GPIO_OFS_OE));
            read_reg(reg_addr(p, `GPIO_OFS_DAT));
        end

        // Back-to-back write then read
        for (int p = 0; p < `GPIO_NUM_PORTS; p++)
        begin
            write_read(reg_addr(p, `GPIO_OFS_OE), $random(seed));
            write_read(reg_addr(p, `GPIO_OFS_DAT), $random(seed));
        end

        repeat (2) @(posedge HCLK);
        if (dut_i.assert_i.fail_cnt != 0)
        begin
            $display("Bound assertions failed %0d times", dut_i.assert_i.fail_cnt);
            $display("Simulation failed");
            $fatal(1);
        end
        else
        begin
            $display("Simulation completed successfully");
            $finish;
        end
    end

endmodule

`default_nettype wire
